/* source/lpif_pkg.sv */
// Link format is fixed at four 40-bit lanes carrying one 141-bit flit per cycle, full rate only
`default_nettype none

package lpif_pkg;

  ////////////////////
  // Lane format

  localparam int NUM_LANES      = 4;
  localparam int LANE_PAYLOAD_W = 38;
  // Four lane payloads hold 152 bits, the flit uses 141
  localparam int FLIT_PAD_W     = 11;

  ////////////////////
  // Flit and lane types

  // LPIF user channel, one flit per clock
  typedef struct packed {
    logic [3:0]   state;
    logic [1:0]   protid;
    logic [127:0] data;
    logic         dvalid;
    logic [3:0]   crc;
    logic         crc_valid;
    logic         valid;
  } lpif_flit_t;

  // One PHY lane word, marker on top
  typedef struct packed {
    logic                      marker;
    logic                      strobe;
    logic [LANE_PAYLOAD_W-1:0] payload;
  } phy_lane_t;

  typedef struct packed {
    logic [FLIT_PAD_W-1:0] pad;
    lpif_flit_t            flit;
  } padded_flit_t;

  // Same 152 bits seen as a flit or as lane slices, lane 0 at the bottom
  typedef union packed {
    padded_flit_t                                padded;
    logic [NUM_LANES-1:0][LANE_PAYLOAD_W-1:0]    lanes;
  } lane_payload_u;

  typedef phy_lane_t [NUM_LANES-1:0] phy_bus_t;

endpackage

`default_nettype wire

/* source/wb_pkg.sv */
// Wishbone classic with 4-bit word addresses and 32-bit data, no wait states, no byte selects
`default_nettype none

package wb_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  ////////////////////
  // Register map

  localparam logic [3:0] ADDR_CTRL    = 4'd0;
  localparam logic [3:0] ADDR_DELAY_X = 4'd1;
  localparam logic [3:0] ADDR_DELAY_Y = 4'd2;
  localparam logic [3:0] ADDR_DELAY_Z = 4'd3;
  localparam logic [3:0] ADDR_STATUS  = 4'd4;

  localparam int CTRL_TX_ONLINE    = 0;
  localparam int CTRL_RX_ONLINE    = 1;
  localparam int STATUS_TX_ONLINE  = 0;
  localparam int STATUS_RX_ONLINE  = 1;
  localparam int STATUS_MARKER_ERR = 2;

  // Settings handed to the auto-sync block
  typedef struct packed {
    logic        tx_online;
    logic        rx_online;
    logic [15:0] delay_x;
    logic [15:0] delay_y;
    logic [15:0] delay_z;
  } sync_cfg_t;

endpackage

`default_nettype wire

/* source/lpif_csr.sv */
// Ack comes one cycle after the request, master must drop stb after ack, unused addresses read 0
`default_nettype none

module lpif_csr (
  input  logic              clk_wr,
  input  logic              rst_n,
  input  wb_pkg::wb_req_t   wb_req,
  output wb_pkg::wb_rsp_t   wb_rsp,
  input  logic              tx_online_delay,
  input  logic              rx_online_delay,
  input  logic              marker_err,
  output wb_pkg::sync_cfg_t cfg
);

  import wb_pkg::*;

  logic        req;
  logic        wr_status;
  logic        marker_err_sticky;
  logic [31:0] status;
  logic [31:0] rd_data;
  sync_cfg_t   cfg_q;

  // New request only, the ack cycle is not counted again
  assign req       = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
  assign wr_status = req && wb_req.we && (wb_req.adr == ADDR_STATUS);
  assign cfg       = cfg_q;

  always_comb begin
    status                    = '0;
    status[STATUS_TX_ONLINE]  = tx_online_delay;
    status[STATUS_RX_ONLINE]  = rx_online_delay;
    status[STATUS_MARKER_ERR] = marker_err_sticky;
  end

  ////////////////////
  // Read mux

  always_comb begin
    rd_data = '0;
    case (wb_req.adr)
      ADDR_CTRL: begin
        rd_data[CTRL_TX_ONLINE] = cfg_q.tx_online;
        rd_data[CTRL_RX_ONLINE] = cfg_q.rx_online;
      end
      ADDR_DELAY_X: rd_data[15:0] = cfg_q.delay_x;
      ADDR_DELAY_Y: rd_data[15:0] = cfg_q.delay_y;
      ADDR_DELAY_Z: rd_data[15:0] = cfg_q.delay_z;
      ADDR_STATUS:  rd_data       = status;
      default:      rd_data       = '0;
    endcase
  end

  ////////////////////
  // Bus response and writes

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wb_rsp <= '0;
      cfg_q  <= '0;
    end else begin
      wb_rsp.ack <= req;
      if (req && !wb_req.we) begin
        wb_rsp.dat <= rd_data;
      end
      if (req && wb_req.we) begin
        case (wb_req.adr)
          ADDR_CTRL: begin
            cfg_q.tx_online <= wb_req.dat[CTRL_TX_ONLINE];
            cfg_q.rx_online <= wb_req.dat[CTRL_RX_ONLINE];
          end
          ADDR_DELAY_X: cfg_q.delay_x <= wb_req.dat[15:0];
          ADDR_DELAY_Y: cfg_q.delay_y <= wb_req.dat[15:0];
          ADDR_DELAY_Z: cfg_q.delay_z <= wb_req.dat[15:0];
          default: ;
        endcase
      end
    end
  end

  // Sticky error, a new error wins over a clear in the same cycle
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      marker_err_sticky <= 1'b0;
    end else if (marker_err) begin
      marker_err_sticky <= 1'b1;
    end else if (wr_status && wb_req.dat[STATUS_MARKER_ERR]) begin
      marker_err_sticky <= 1'b0;
    end
  end

  a_ack_needs_req : assert property (@(posedge clk_wr) disable iff (!rst_n)
    wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
    else $error("ack high without a bus request");

endmodule

`default_nettype wire

/* source/lpif_auto_sync.sv */
// Marker and strobe are always generated; a delay_z of 0 spaces the strobe as 1
`default_nettype none

module lpif_auto_sync (
  input  logic              clk_wr,
  input  logic              rst_n,
  input  wb_pkg::sync_cfg_t cfg,
  output logic              tx_online_delay,
  output logic              rx_online_delay,
  output logic              marker,
  output logic              strobe
);

  logic        rx_en;
  logic [15:0] tx_cnt;
  logic [15:0] rx_cnt;
  logic [15:0] stb_cnt;
  logic [15:0] stb_last;

  // Rx side also drops at the same edge as tx when tx_online clears
  assign rx_en = cfg.rx_online && cfg.tx_online && tx_online_delay;

  ////////////////////
  // Online delays

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_cnt          <= '0;
      tx_online_delay <= 1'b0;
    end else if (!cfg.tx_online) begin
      tx_cnt          <= '0;
      tx_online_delay <= 1'b0;
    end else if (tx_cnt >= cfg.delay_x) begin
      tx_online_delay <= 1'b1;
    end else begin
      tx_cnt <= tx_cnt + 16'd1;
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_en) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (rx_cnt >= cfg.delay_y) begin
      rx_online_delay <= 1'b1;
    end else begin
      rx_cnt <= rx_cnt + 16'd1;
    end
  end

  ////////////////////
  // Marker and strobe

  assign stb_last = (cfg.delay_z == 16'd0) ? 16'd0 : cfg.delay_z - 16'd1;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      stb_cnt <= '0;
    end else if (!tx_online_delay || stb_cnt >= stb_last) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 16'd1;
    end
  end

  // Marker on every online word
  assign marker = tx_online_delay;
  assign strobe = tx_online_delay && (stb_cnt == 16'd0);

  a_rx_after_tx : assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_online_delay |-> tx_online_delay)
    else $error("rx online while tx is offline");

endmodule

`default_nettype wire

/* source/lpif_flit_tx.sv */
// One register stage from dstrm to tx_phy; lanes send all zero while tx is offline
`default_nettype none

module lpif_flit_tx (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  input  lpif_pkg::lpif_flit_t dstrm,
  input  logic                 tx_online_delay,
  input  logic                 marker,
  input  logic                 strobe,
  output lpif_pkg::phy_bus_t   tx_phy
);

  import lpif_pkg::*;

  lane_payload_u pl;
  phy_bus_t      lane_word;

  ////////////////////
  // Flit to lanes

  // Pad bits sit above the flit
  assign pl.padded = {{FLIT_PAD_W{1'b0}}, dstrm};

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_word[i].marker  = marker;
      lane_word[i].strobe  = strobe;
      lane_word[i].payload = pl.lanes[i];
    end
  end

  ////////////////////
  // Output register

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else if (tx_online_delay) begin
      tx_phy <= lane_word;
    end else begin
      tx_phy <= '0;
    end
  end

  a_quiet_offline : assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online_delay |=> (tx_phy == '0))
    else $error("tx_phy active after an offline cycle");

endmodule

`default_nettype wire

/* source/lpif_flit_rx.sv */
// One register stage from rx_phy to ustrm; the pad bits of the lanes are ignored
`default_nettype none

module lpif_flit_rx (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  input  lpif_pkg::phy_bus_t   rx_phy,
  input  logic                 rx_online_delay,
  output lpif_pkg::lpif_flit_t ustrm,
  output logic                 marker_err
);

  import lpif_pkg::*;

  lane_payload_u        pl;
  logic [NUM_LANES-1:0] lane_marker;

  ////////////////////
  // Lanes to flit

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      pl.lanes[i]    = rx_phy[i].payload;
      lane_marker[i] = rx_phy[i].marker;
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ustrm <= '0;
    end else if (rx_online_delay) begin
      ustrm <= pl.padded.flit;
    end else begin
      ustrm <= '0;
    end
  end

  ////////////////////
  // Marker check

  // Every online word must carry the marker on all lanes
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      marker_err <= 1'b0;
    end else begin
      marker_err <= rx_online_delay && !(&lane_marker);
    end
  end

  a_valid_online : assert property (@(posedge clk_wr) disable iff (!rst_n)
    ustrm.valid |-> $past(rx_online_delay))
    else $error("ustrm valid without rx online");

endmodule

`default_nettype wire

/* source/lpif_x4_top.sv */
// Single clock domain, Gen2 full rate only, no link-layer FIFO or credits
`default_nettype none

module lpif_x4_top (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  input  wb_pkg::wb_req_t      wb_req,
  output wb_pkg::wb_rsp_t      wb_rsp,
  input  lpif_pkg::lpif_flit_t dstrm,
  output lpif_pkg::lpif_flit_t ustrm,
  output lpif_pkg::phy_bus_t   tx_phy,
  input  lpif_pkg::phy_bus_t   rx_phy
);

  import wb_pkg::*;

  sync_cfg_t cfg;
  logic      tx_online_delay;
  logic      rx_online_delay;
  logic      marker;
  logic      strobe;
  logic      marker_err;

  ////////////////////
  // Registers

  lpif_csr u_csr (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .wb_req          (wb_req),
    .wb_rsp          (wb_rsp),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .marker_err      (marker_err),
    .cfg             (cfg)
  );

  ////////////////////
  // Auto sync

  lpif_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .cfg             (cfg),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .marker          (marker),
    .strobe          (strobe)
  );

  ////////////////////
  // PHY paths

  lpif_flit_tx u_flit_tx (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .dstrm           (dstrm),
    .tx_online_delay (tx_online_delay),
    .marker          (marker),
    .strobe          (strobe),
    .tx_phy          (tx_phy)
  );

  lpif_flit_rx u_flit_rx (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .rx_phy          (rx_phy),
    .rx_online_delay (rx_online_delay),
    .ustrm           (ustrm),
    .marker_err      (marker_err)
  );

endmodule

`default_nettype wire

/* verification/lpif_x4_tb.sv */
// Loopback testbench for lpif_x4_top; rx_phy follows tx_phy, checks stop at the first mismatch
`default_nettype none

module lpif_x4_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import lpif_pkg::*;
  import wb_pkg::*;

  localparam logic [31:0] SEED = 32'h6b1da026;
  localparam int TABLE_LEN      = 12;
  localparam int DELAY_X        = 5;
  localparam int DELAY_Y        = 3;
  localparam int DELAY_Z        = 4;
  localparam int NUM_ACCESSES   = 24;
  localparam int ACK_WAIT_MAX   = 4;
  localparam int TIMEOUT_CYCLES =
    20 * (TABLE_LEN + DELAY_X + DELAY_Y + DELAY_Z + NUM_ACCESSES);

  logic       clk_wr;
  logic       rst_n;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  lpif_flit_t dstrm;
  lpif_flit_t ustrm;
  phy_bus_t   tx_phy;
  phy_bus_t   rx_phy;
  logic       corrupt;
  lpif_flit_t tx_ref;
  phy_bus_t   phy_at_ack;
  lpif_flit_t stim_table [TABLE_LEN];
  lpif_flit_t exp_q [$];
  int         cycle_cnt;
  int         word_idx;

  lpif_x4_top u_lpif_x4_top (
    .clk_wr (clk_wr),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .dstrm  (dstrm),
    .ustrm  (ustrm),
    .tx_phy (tx_phy),
    .rx_phy (rx_phy)
  );

  initial clk_wr = 1'b0;
  always #2 clk_wr = ~clk_wr;

  // Loopback, lane 2 loses its marker while corrupt is set
  always_comb begin
    rx_phy = tx_phy;
    if (corrupt) begin
      rx_phy[2].marker = 1'b0;
    end
  end

  ////////////////////
  // Checks

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopping at the first failure");
  endtask

  task automatic check_flit(input string name, input lpif_flit_t act, input lpif_flit_t exp);
    if (act !== exp) begin
      $display("** Error: %s actual %h expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_lane(input string name, input phy_lane_t act, input phy_lane_t exp);
    if (act !== exp) begin
      $display("** Error: %s actual %h expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("** Error: %s actual %h expected %h", name, act, exp);
      abort_run();
    end
  endtask

  // Lane n carries bits 38n+37 down to 38n of the zero-padded flit
  function automatic logic [37:0] lane_slice(input lpif_flit_t f, input int n);
    logic [151:0] padded;
    padded = {11'b0, f};
    return padded[38*n +: 38];
  endfunction

  always @(posedge clk_wr) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      abort_run();
    end
  end

  // Flit that tx_phy should carry after each edge
  always @(posedge clk_wr) begin
    tx_ref <= dstrm;
  end

  // Every tx word is either all zero or a marked lane word of tx_ref
  always @(negedge clk_wr) begin
    phy_lane_t exp_lane;
    if (rst_n) begin
      for (int n = 0; n < NUM_LANES; n++) begin
        exp_lane = '0;
        if (tx_phy[0].marker) begin
          exp_lane.marker  = 1'b1;
          exp_lane.strobe  = (word_idx % DELAY_Z == 0);
          exp_lane.payload = lane_slice(tx_ref, n);
        end
        check_lane($sformatf("tx_phy[%0d]", n), tx_phy[n], exp_lane);
      end
      word_idx <= tx_phy[0].marker ? word_idx + 1 : 0;
    end
  end

  ////////////////////
  // Bus access

  task automatic wait_ack();
    int waited;
    waited = 0;
    @(negedge clk_wr);
    while (!wb_rsp.ack) begin
      waited++;
      if (waited >= ACK_WAIT_MAX) begin
        $display("No Wishbone ack within %0d cycles", ACK_WAIT_MAX);
        abort_run();
      end
      @(negedge clk_wr);
    end
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
    wb_req_t req;
    req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    @(posedge clk_wr);
    wb_req <= req;
    wait_ack();
    @(posedge clk_wr);
    wb_req <= '0;
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
    wb_req_t req;
    req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
    @(posedge clk_wr);
    wb_req <= req;
    wait_ack();
    dat        = wb_rsp.dat;
    phy_at_ack = tx_phy;
    @(posedge clk_wr);
    wb_req <= '0;
  endtask

  // Read STATUS until a bit is set; tx lanes must stay quiet before tx is online
  task automatic poll_status(input int bit_pos, output logic [31:0] rd);
    int polls;
    polls = 0;
    wb_read(ADDR_STATUS, rd);
    while (!rd[bit_pos]) begin
      if (bit_pos == STATUS_TX_ONLINE) begin
        for (int n = 0; n < NUM_LANES; n++) begin
          check_lane($sformatf("tx_phy[%0d]", n), phy_at_ack[n], '0);
        end
      end
      polls++;
      if (polls > DELAY_X + DELAY_Y + 4) begin
        $display("STATUS bit %0d never came up", bit_pos);
        abort_run();
      end
      wb_read(ADDR_STATUS, rd);
    end
  endtask

  task automatic build_table();
    logic [31:0] r;
    for (int i = 0; i < TABLE_LEN; i++) begin
      r = $urandom;
      stim_table[i].state     = r[3:0];
      stim_table[i].protid    = r[5:4];
      stim_table[i].data      = {$urandom, $urandom, $urandom, $urandom};
      stim_table[i].dvalid    = r[6];
      stim_table[i].crc       = r[10:7];
      stim_table[i].crc_valid = r[11];
      stim_table[i].valid     = 1'b1;
    end
  endtask

  ////////////////////
  // Sequence

  initial begin
    logic [31:0] rd;
    rst_n   <= 1'b0;
    wb_req  <= '0;
    dstrm   <= '0;
    corrupt <= 1'b0;
    void'($urandom(SEED));
    build_table();
    repeat (3) @(posedge clk_wr);
    rst_n <= 1'b1;

    @(negedge clk_wr);
    check_word("wb_rsp.ack", {31'b0, wb_rsp.ack}, '0);
    check_flit("ustrm", ustrm, '0);
    for (int n = 0; n < NUM_LANES; n++) begin
      check_lane($sformatf("tx_phy[%0d]", n), tx_phy[n], '0);
    end
    wb_read(ADDR_STATUS, rd);
    check_word("status", rd, '0);
    wb_write(ADDR_DELAY_X, DELAY_X);
    wb_write(ADDR_DELAY_Y, DELAY_Y);
    wb_write(ADDR_DELAY_Z, DELAY_Z);
    wb_read(ADDR_DELAY_X, rd);
    check_word("delay_x", rd, DELAY_X);
    wb_read(ADDR_DELAY_Y, rd);
    check_word("delay_y", rd, DELAY_Y);
    wb_read(ADDR_DELAY_Z, rd);
    check_word("delay_z", rd, DELAY_Z);

    // Tx comes online first, rx follows
    wb_write(ADDR_CTRL, 32'h3);
    poll_status(STATUS_TX_ONLINE, rd);
    check_word("status.rx_online", {30'b0, rd[1], 1'b0}, '0);
    poll_status(STATUS_RX_ONLINE, rd);

    // Row i shows up on ustrm two edges after it is driven
    for (int i = 0; i < TABLE_LEN + 2; i++) begin
      @(posedge clk_wr);
      if (i < TABLE_LEN) begin
        dstrm <= stim_table[i];
        exp_q.push_back(stim_table[i]);
      end else begin
        dstrm <= '0;
      end
      @(negedge clk_wr);
      if (i >= 2) begin
        check_flit("ustrm", ustrm, exp_q.pop_front());
      end
    end

    @(posedge clk_wr);
    corrupt <= 1'b1;
    @(posedge clk_wr);
    corrupt <= 1'b0;
    repeat (2) @(posedge clk_wr);
    wb_read(ADDR_STATUS, rd);
    check_word("status", rd, 32'h7);
    wb_write(ADDR_STATUS, 32'h4);
    wb_read(ADDR_STATUS, rd);
    check_word("status", rd, 32'h3);

    // Two edges after the CTRL write lands
    wb_write(ADDR_CTRL, 32'h0);
    @(posedge clk_wr);
    @(negedge clk_wr);
    check_flit("ustrm", ustrm, '0);
    for (int n = 0; n < NUM_LANES; n++) begin
      check_lane($sformatf("tx_phy[%0d]", n), tx_phy[n], '0);
    end
    wb_read(ADDR_STATUS, rd);
    check_word("status", rd, '0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
source/lpif_pkg.sv
source/wb_pkg.sv
source/lpif_csr.sv
source/lpif_auto_sync.sv
source/lpif_flit_tx.sv
source/lpif_flit_rx.sv
source/lpif_x4_top.sv
verification/lpif_x4_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lpif_x4_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)
